// File: design/valu_pkg.sv
`default_nettype none

package valu_pkg;

    localparam int data_width   = 64;
    localparam int be_width     = data_width / 8;
    localparam int addr_width   = 32;
    localparam int funct6_width = 6;
    localparam int unit_latency = 2;  // cycles inside each execute unit

    // element width is 8 << sew
    typedef enum logic [1:0] {
        sew_8,
        sew_16,
        sew_32,
        sew_64
    } sew_e;

    typedef enum logic [2:0] {
        opivv = 3'd0,
        opivi = 3'd3,
        opivx = 3'd4
    } op_minor_e;

    typedef enum logic [funct6_width-1:0] {
        f_vadd   = 6'b000000,
        f_vsub   = 6'b000010,
        f_vrsub  = 6'b000011,
        f_vminu  = 6'b000100,
        f_vmin   = 6'b000101,
        f_vmaxu  = 6'b000110,
        f_vmax   = 6'b000111,
        f_vand   = 6'b001001,
        f_vor    = 6'b001010,
        f_vxor   = 6'b001011,
        f_vmerge = 6'b010111
    } funct6_e;

    typedef enum logic [3:0] {
        op_none,
        op_and,
        op_or,
        op_xor,
        op_move,
        op_merge,
        op_add,
        op_sub,
        op_rsub,
        op_minu,
        op_min,
        op_maxu,
        op_max
    } valu_op_e;

endpackage

`default_nettype wire

// File: design/valu_decode.sv
`timescale 1ns/10ps
`default_nettype none

module valu_decode (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 req_valid,
    input  logic [valu_pkg::funct6_width-1:0]    req_func_id,
    input  logic [2:0]                           req_op_mnr,
    input  logic [1:0]                           req_sew,
    input  logic [valu_pkg::data_width-1:0]      req_data0,
    input  logic [valu_pkg::data_width-1:0]      req_data1,
    input  logic [valu_pkg::addr_width-1:0]      req_addr,
    input  logic [valu_pkg::be_width-1:0]        req_be,
    input  logic                                 req_start,
    input  logic                                 req_end,
    input  logic                                 req_mask,
    output logic                                 s1_valid,
    output valu_pkg::valu_op_e                   s1_op,
    output logic [1:0]                           s1_sew,
    output logic [valu_pkg::data_width-1:0]      s1_data0,
    output logic [valu_pkg::data_width-1:0]      s1_data1,
    output logic [valu_pkg::be_width-1:0]        s1_be,
    output logic [valu_pkg::addr_width-1:0]      s1_addr,
    output logic                                 s1_start,
    output logic                                 s1_end
);

    valu_pkg::valu_op_e op_next;
    logic               take;

    always_comb begin
        case (req_func_id)
            valu_pkg::f_vadd:   op_next = valu_pkg::op_add;
            valu_pkg::f_vsub:   op_next = valu_pkg::op_sub;
            valu_pkg::f_vrsub:  op_next = valu_pkg::op_rsub;
            valu_pkg::f_vminu:  op_next = valu_pkg::op_minu;
            valu_pkg::f_vmin:   op_next = valu_pkg::op_min;
            valu_pkg::f_vmaxu:  op_next = valu_pkg::op_maxu;
            valu_pkg::f_vmax:   op_next = valu_pkg::op_max;
            valu_pkg::f_vand:   op_next = valu_pkg::op_and;
            valu_pkg::f_vor:    op_next = valu_pkg::op_or;
            valu_pkg::f_vxor:   op_next = valu_pkg::op_xor;
            valu_pkg::f_vmerge: op_next = req_mask ? valu_pkg::op_move : valu_pkg::op_merge;
            default:            op_next = valu_pkg::op_none;
        endcase
        if (!(req_op_mnr inside {valu_pkg::opivv, valu_pkg::opivi, valu_pkg::opivx})) begin
            op_next = valu_pkg::op_none;  // opmvv, opfvv and the rest
        end
    end

    assign take = req_valid && (op_next != valu_pkg::op_none);

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s1_op    <= valu_pkg::op_none;
            s1_start <= 1'b0;
            s1_end   <= 1'b0;
        end else begin
            s1_valid <= take;
            s1_op    <= take ? op_next : valu_pkg::op_none;
            s1_start <= take && req_start;
            s1_end   <= take && req_end;
        end
    end

    always_ff @(posedge clk) begin
        s1_sew   <= req_sew;
        s1_data0 <= req_data0;
        s1_data1 <= req_data1;
        s1_be    <= req_be;
        s1_addr  <= req_addr;
    end

endmodule

`default_nettype wire

// File: design/valu_logic_unit.sv
`timescale 1ns/10ps
`default_nettype none

module valu_logic_unit (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               s1_valid,
    input  valu_pkg::valu_op_e                 s1_op,
    input  logic [valu_pkg::data_width-1:0]    s1_data0,
    input  logic [valu_pkg::data_width-1:0]    s1_data1,
    input  logic [valu_pkg::be_width-1:0]      s1_be,
    output logic                               logic_valid,
    output logic [valu_pkg::data_width-1:0]    logic_data
);

    logic                            hit;
    logic [valu_pkg::data_width-1:0] res;
    logic                            v2;
    logic [valu_pkg::data_width-1:0] d2;

    assign hit = s1_valid && (s1_op inside {valu_pkg::op_and, valu_pkg::op_or,
                                            valu_pkg::op_xor, valu_pkg::op_move,
                                            valu_pkg::op_merge});

    always_comb begin
        res = '0;  // zero when idle so the merge stage can OR
        case (s1_op)
            valu_pkg::op_and:  res = s1_data1 & s1_data0;
            valu_pkg::op_or:   res = s1_data1 | s1_data0;
            valu_pkg::op_xor:  res = s1_data1 ^ s1_data0;
            valu_pkg::op_move: res = s1_data0;
            valu_pkg::op_merge: begin
                for (int i = 0; i < valu_pkg::be_width; i++) begin
                    res[8*i +: 8] = s1_be[i] ? s1_data0[8*i +: 8] : s1_data1[8*i +: 8];
                end
            end
            default: res = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            v2          <= 1'b0;
            logic_valid <= 1'b0;
        end else begin
            v2          <= hit;
            logic_valid <= v2;
        end
    end

    always_ff @(posedge clk) begin
        d2         <= res;
        logic_data <= d2;  // retiming slot
    end

endmodule

`default_nettype wire

// File: design/valu_arith_unit.sv
`timescale 1ns/10ps
`default_nettype none

module valu_arith_unit (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               s1_valid,
    input  valu_pkg::valu_op_e                 s1_op,
    input  logic [1:0]                         s1_sew,
    input  logic [valu_pkg::data_width-1:0]    s1_data0,
    input  logic [valu_pkg::data_width-1:0]    s1_data1,
    output logic                               arith_valid,
    output logic [valu_pkg::data_width-1:0]    arith_data
);

    localparam int dw = valu_pkg::data_width;
    localparam int bw = valu_pkg::be_width;

    // low byte-index bits that stay inside one element
    function automatic logic [2:0] elem_mask(input logic [1:0] sew);
        case (sew)
            valu_pkg::sew_8:  return 3'd0;
            valu_pkg::sew_16: return 3'd1;
            valu_pkg::sew_32: return 3'd3;
            default:          return 3'd7;
        endcase
    endfunction

    // byte-wise adder, carry restarts at each element boundary
    function automatic logic [dw-1:0] lane_add(input logic [dw-1:0] a, input logic [dw-1:0] b,
                                               input logic sub, input logic [2:0] mask);
        logic [dw-1:0] s;
        logic [7:0]    bb;
        logic [8:0]    t;
        logic          c;
        c = 1'b0;
        for (int i = 0; i < bw; i++) begin
            if ((i[2:0] & mask) == 3'd0) begin
                c = sub;  // +1 of the two's complement
            end
            bb = sub ? ~b[8*i +: 8] : b[8*i +: 8];
            t  = {1'b0, a[8*i +: 8]} + {1'b0, bb} + {8'd0, c};
            s[8*i +: 8] = t[7:0];
            c  = t[8];
        end
        return s;
    endfunction

    logic               hit;
    logic [2:0]         mask;
    logic [dw-1:0]      sum_c, diff_c, rdiff_c;
    logic [bw-1:0]      slt_c, ult_c;
    logic               v2;
    valu_pkg::valu_op_e op2;
    logic [dw-1:0]      sum2, diff2, rdiff2, d0_2, d1_2;
    logic [bw-1:0]      slt2, ult2;
    logic [dw-1:0]      res;

    assign hit = s1_valid && (s1_op inside {valu_pkg::op_add, valu_pkg::op_sub,
                                            valu_pkg::op_rsub, valu_pkg::op_minu,
                                            valu_pkg::op_min, valu_pkg::op_maxu,
                                            valu_pkg::op_max});

    always_comb begin
        logic at, bt, dt, slt_cur, ult_cur;
        at      = 1'b0;
        bt      = 1'b0;
        dt      = 1'b0;
        slt_cur = 1'b0;
        ult_cur = 1'b0;
        mask    = elem_mask(s1_sew);
        sum_c   = lane_add(s1_data1, s1_data0, 1'b0, mask);
        diff_c  = lane_add(s1_data1, s1_data0, 1'b1, mask);
        rdiff_c = lane_add(s1_data0, s1_data1, 1'b1, mask);
        // walk down so each element's top byte is seen first
        for (int i = bw - 1; i >= 0; i--) begin
            if ((i[2:0] & mask) == mask) begin
                at      = s1_data1[8*i+7];
                bt      = s1_data0[8*i+7];
                dt      = diff_c[8*i+7];
                slt_cur = (at != bt) ? at : dt;
                ult_cur = (at != bt) ? bt : dt;
            end
            slt_c[i] = slt_cur;  // data1 < data0, signed
            ult_c[i] = ult_cur;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            v2          <= 1'b0;
            op2         <= valu_pkg::op_none;
            arith_valid <= 1'b0;
        end else begin
            v2          <= hit;
            op2         <= hit ? s1_op : valu_pkg::op_none;
            arith_valid <= v2;
        end
    end

    always_ff @(posedge clk) begin
        sum2   <= sum_c;
        diff2  <= diff_c;
        rdiff2 <= rdiff_c;
        slt2   <= slt_c;
        ult2   <= ult_c;
        d0_2   <= s1_data0;
        d1_2   <= s1_data1;
    end

    always_comb begin
        logic [7:0] x, y;
        res = '0;
        for (int i = 0; i < bw; i++) begin
            x = d1_2[8*i +: 8];
            y = d0_2[8*i +: 8];
            case (op2)
                valu_pkg::op_add:  res[8*i +: 8] = sum2[8*i +: 8];
                valu_pkg::op_sub:  res[8*i +: 8] = diff2[8*i +: 8];
                valu_pkg::op_rsub: res[8*i +: 8] = rdiff2[8*i +: 8];
                valu_pkg::op_minu: res[8*i +: 8] = ult2[i] ? x : y;
                valu_pkg::op_min:  res[8*i +: 8] = slt2[i] ? x : y;
                valu_pkg::op_maxu: res[8*i +: 8] = ult2[i] ? y : x;
                valu_pkg::op_max:  res[8*i +: 8] = slt2[i] ? y : x;
                default:           res[8*i +: 8] = 8'd0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        arith_data <= res;
    end

endmodule

`default_nettype wire

// File: design/valu_resp_merge.sv
`timescale 1ns/10ps
`default_nettype none

module valu_resp_merge (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               logic_valid,
    input  logic [valu_pkg::data_width-1:0]    logic_data,
    input  logic                               arith_valid,
    input  logic [valu_pkg::data_width-1:0]    arith_data,
    input  logic                               s1_valid,
    input  logic [valu_pkg::addr_width-1:0]    s1_addr,
    input  logic                               s1_start,
    input  logic                               s1_end,
    input  logic [valu_pkg::be_width-1:0]      s1_be,
    input  logic [1:0]                         s1_sew,
    output logic                               resp_valid,
    output logic [valu_pkg::data_width-1:0]    resp_data,
    output logic [valu_pkg::addr_width-1:0]    resp_addr,
    output logic [valu_pkg::be_width-1:0]      resp_be,
    output logic [1:0]                         resp_sew,
    output logic                               resp_start,
    output logic                               resp_end
);

    localparam int depth = valu_pkg::unit_latency;
    localparam int last  = depth - 1;

    // sideband delay line, one entry per unit stage
    logic                            v_q     [depth];
    logic                            start_q [depth];
    logic                            end_q   [depth];
    logic [valu_pkg::addr_width-1:0] addr_q  [depth];
    logic [valu_pkg::be_width-1:0]   be_q    [depth];
    logic [1:0]                      sew_q   [depth];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < depth; k++) begin
                v_q[k]     <= 1'b0;
                start_q[k] <= 1'b0;
                end_q[k]   <= 1'b0;
            end
        end else begin
            v_q[0]     <= s1_valid;
            start_q[0] <= s1_start;
            end_q[0]   <= s1_end;
            for (int k = 1; k < depth; k++) begin
                v_q[k]     <= v_q[k-1];
                start_q[k] <= start_q[k-1];
                end_q[k]   <= end_q[k-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        addr_q[0] <= s1_addr;
        be_q[0]   <= s1_be;
        sew_q[0]  <= s1_sew;
        for (int k = 1; k < depth; k++) begin
            addr_q[k] <= addr_q[k-1];
            be_q[k]   <= be_q[k-1];
            sew_q[k]  <= sew_q[k-1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid <= 1'b0;
            resp_data  <= '0;
            resp_addr  <= '0;
            resp_be    <= '0;
            resp_sew   <= '0;
            resp_start <= 1'b0;
            resp_end   <= 1'b0;
        end else begin
            resp_valid <= logic_valid || arith_valid;
            resp_data  <= logic_data | arith_data;  // idle unit drives zero
            resp_addr  <= v_q[last] ? addr_q[last] : '0;
            resp_be    <= v_q[last] ? be_q[last] : '0;
            resp_sew   <= v_q[last] ? sew_q[last] : 2'd0;
            resp_start <= v_q[last] && start_q[last];
            resp_end   <= v_q[last] && end_q[last];
        end
    end

endmodule

`default_nettype wire

// File: design/valu_top.sv
`timescale 1ns/10ps
`default_nettype none

module valu_top (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 req_valid,
    input  logic [valu_pkg::funct6_width-1:0]    req_func_id,
    input  logic [2:0]                           req_op_mnr,
    input  logic [1:0]                           req_sew,
    input  logic [valu_pkg::data_width-1:0]      req_data0,
    input  logic [valu_pkg::data_width-1:0]      req_data1,
    input  logic [valu_pkg::addr_width-1:0]      req_addr,
    input  logic [valu_pkg::be_width-1:0]        req_be,
    input  logic                                 req_start,
    input  logic                                 req_end,
    input  logic                                 req_mask,
    output logic                                 resp_valid,
    output logic [valu_pkg::data_width-1:0]      resp_data,
    output logic [valu_pkg::addr_width-1:0]      resp_addr,
    output logic [valu_pkg::be_width-1:0]        resp_be,
    output logic [1:0]                           resp_sew,
    output logic                                 resp_start,
    output logic                                 resp_end
);

    logic                            s1_valid;
    valu_pkg::valu_op_e              s1_op;
    logic [1:0]                      s1_sew;
    logic [valu_pkg::data_width-1:0] s1_data0;
    logic [valu_pkg::data_width-1:0] s1_data1;
    logic [valu_pkg::be_width-1:0]   s1_be;
    logic [valu_pkg::addr_width-1:0] s1_addr;
    logic                            s1_start;
    logic                            s1_end;
    logic                            logic_valid;
    logic [valu_pkg::data_width-1:0] logic_data;
    logic                            arith_valid;
    logic [valu_pkg::data_width-1:0] arith_data;

    valu_decode u_decode (
        .clk(clk), .rst(rst),
        .req_valid(req_valid), .req_func_id(req_func_id), .req_op_mnr(req_op_mnr),
        .req_sew(req_sew), .req_data0(req_data0), .req_data1(req_data1),
        .req_addr(req_addr), .req_be(req_be), .req_start(req_start),
        .req_end(req_end), .req_mask(req_mask),
        .s1_valid(s1_valid), .s1_op(s1_op), .s1_sew(s1_sew),
        .s1_data0(s1_data0), .s1_data1(s1_data1), .s1_be(s1_be),
        .s1_addr(s1_addr), .s1_start(s1_start), .s1_end(s1_end)
    );

    valu_logic_unit u_logic (
        .clk(clk), .rst(rst),
        .s1_valid(s1_valid), .s1_op(s1_op), .s1_data0(s1_data0),
        .s1_data1(s1_data1), .s1_be(s1_be),
        .logic_valid(logic_valid), .logic_data(logic_data)
    );

    valu_arith_unit u_arith (
        .clk(clk), .rst(rst),
        .s1_valid(s1_valid), .s1_op(s1_op), .s1_sew(s1_sew),
        .s1_data0(s1_data0), .s1_data1(s1_data1),
        .arith_valid(arith_valid), .arith_data(arith_data)
    );

    valu_resp_merge u_resp (
        .clk(clk), .rst(rst),
        .logic_valid(logic_valid), .logic_data(logic_data),
        .arith_valid(arith_valid), .arith_data(arith_data),
        .s1_valid(s1_valid), .s1_addr(s1_addr), .s1_start(s1_start),
        .s1_end(s1_end), .s1_be(s1_be), .s1_sew(s1_sew),
        .resp_valid(resp_valid), .resp_data(resp_data), .resp_addr(resp_addr),
        .resp_be(resp_be), .resp_sew(resp_sew), .resp_start(resp_start),
        .resp_end(resp_end)
    );

endmodule

`default_nettype wire

// File: verif/valu_sva.sv
`timescale 1ns/10ps
`default_nettype none

module valu_sva (
    input logic                                 clk,
    input logic                                 rst,
    input logic                                 req_valid,
    input logic [valu_pkg::funct6_width-1:0]    req_func_id,
    input logic [2:0]                           req_op_mnr,
    input logic                                 resp_valid,
    input logic [valu_pkg::data_width-1:0]      resp_data,
    input logic [valu_pkg::addr_width-1:0]      resp_addr,
    input logic [valu_pkg::be_width-1:0]        resp_be,
    input logic [1:0]                           resp_sew,
    input logic                                 resp_start,
    input logic                                 resp_end
);

    logic legal;

    assign legal = req_valid
        && (req_op_mnr inside {valu_pkg::opivv, valu_pkg::opivi, valu_pkg::opivx})
        && (req_func_id inside {valu_pkg::f_vadd, valu_pkg::f_vsub, valu_pkg::f_vrsub,
                                valu_pkg::f_vminu, valu_pkg::f_vmin, valu_pkg::f_vmaxu,
                                valu_pkg::f_vmax, valu_pkg::f_vand, valu_pkg::f_vor,
                                valu_pkg::f_vxor, valu_pkg::f_vmerge});

    resp_follows_req: assert property (@(posedge clk) disable iff (rst)
        legal |-> ##4 resp_valid)
        else $error("no response four cycles after a legal request");

    resp_has_req: assert property (@(posedge clk) disable iff (rst)
        resp_valid |-> $past(legal, 4))
        else $error("response without a legal request four cycles earlier");

    flags_need_valid: assert property (@(posedge clk) disable iff (rst)
        (resp_start || resp_end) |-> resp_valid)
        else $error("resp_start or resp_end raised without resp_valid");

    // outputs come out of reset cleared
    quiet_after_reset: assert property (@(posedge clk)
        $past(rst) |-> (!resp_valid && !resp_start && !resp_end && resp_data == '0
                        && resp_addr == '0 && resp_be == '0 && resp_sew == '0))
        else $error("outputs not cleared after reset");

endmodule

`default_nettype wire

// File: verif/valu_tb.sv
`timescale 1ns/10ps
`default_nettype none

module valu_tb;

    logic        clk;
    logic        rst;
    logic        req_valid;
    logic [5:0]  req_func_id;
    logic [2:0]  req_op_mnr;
    logic [1:0]  req_sew;
    logic [63:0] req_data0;
    logic [63:0] req_data1;
    logic [31:0] req_addr;
    logic [7:0]  req_be;
    logic        req_start;
    logic        req_end;
    logic        req_mask;
    logic        resp_valid;
    logic [63:0] resp_data;
    logic [31:0] resp_addr;
    logic [7:0]  resp_be;
    logic [1:0]  resp_sew;
    logic        resp_start;
    logic        resp_end;

    logic [31:0] lfsr;
    int unsigned cyc = 0;
    string       name_q[$];
    logic [63:0] data_q[$];
    logic [43:0] side_q[$];  // {sew, start, end, be, addr}
    int unsigned due_q[$];

    valu_top DUT (.*);

    bind valu_top valu_sva u_sva (
        .clk(clk), .rst(rst), .req_valid(req_valid), .req_func_id(req_func_id),
        .req_op_mnr(req_op_mnr), .resp_valid(resp_valid), .resp_data(resp_data),
        .resp_addr(resp_addr), .resp_be(resp_be), .resp_sew(resp_sew),
        .resp_start(resp_start), .resp_end(resp_end)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check(input string what, input logic [63:0] exp, input logic [63:0] act);
        assert (act === exp)
            else fail_stop($sformatf("CHECK FAILED %s: expected %h actual %h", what, exp, act));
    endtask

    function automatic logic lfsr_step();
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        return lfsr[0];
    endfunction

    task automatic rand_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], lfsr_step()};
        end
    endtask

    function automatic logic is_legal(input logic [5:0] f6, input logic [2:0] mnr);
        return (mnr inside {valu_pkg::opivv, valu_pkg::opivi, valu_pkg::opivx})
            && (f6 inside {valu_pkg::f_vadd, valu_pkg::f_vsub, valu_pkg::f_vrsub,
                           valu_pkg::f_vminu, valu_pkg::f_vmin, valu_pkg::f_vmaxu,
                           valu_pkg::f_vmax, valu_pkg::f_vand, valu_pkg::f_vor,
                           valu_pkg::f_vxor, valu_pkg::f_vmerge});
    endfunction

    // element-wise reference, d1 is vs2 and d0 is vs1 or scalar
    function automatic logic [63:0] model(input logic [5:0] f6, input logic mask,
                                          input logic [1:0] sew, input logic [63:0] d0,
                                          input logic [63:0] d1, input logic [7:0] be);
        int          w;
        logic [63:0] wm;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] r;
        logic [63:0] out;
        logic        ul;
        logic        sl;
        out = '0;
        if (f6 == valu_pkg::f_vmerge) begin
            for (int i = 0; i < 8; i++) begin
                out[8*i +: 8] = (mask || be[i]) ? d0[8*i +: 8] : d1[8*i +: 8];
            end
            return out;
        end
        w  = 8 << sew;
        wm = (w == 64) ? '1 : ((64'd1 << w) - 64'd1);
        for (int e = 0; e < 64 / w; e++) begin
            a  = (d1 >> (e * w)) & wm;
            b  = (d0 >> (e * w)) & wm;
            ul = a < b;
            sl = $signed(a << (64 - w)) < $signed(b << (64 - w));  // sign bit moved to the top
            case (f6)
                valu_pkg::f_vadd:  r = a + b;
                valu_pkg::f_vsub:  r = a - b;
                valu_pkg::f_vrsub: r = b - a;
                valu_pkg::f_vminu: r = ul ? a : b;
                valu_pkg::f_vmin:  r = sl ? a : b;
                valu_pkg::f_vmaxu: r = ul ? b : a;
                valu_pkg::f_vmax:  r = sl ? b : a;
                valu_pkg::f_vand:  r = a & b;
                valu_pkg::f_vor:   r = a | b;
                valu_pkg::f_vxor:  r = a ^ b;
                default:           r = '0;
            endcase
            out = out | ((r & wm) << (e * w));
        end
        return out;
    endfunction

    task automatic send(input string name, input logic [5:0] f6, input logic [2:0] mnr,
                        input logic [1:0] sew, input logic [63:0] d0, input logic [63:0] d1,
                        input logic mask);
        logic [63:0] r;
        @(negedge clk);
        rand_bits(32, r);
        req_addr = r[31:0];
        rand_bits(8, r);
        req_be = r[7:0];
        rand_bits(2, r);
        req_start   = r[0];
        req_end     = r[1];
        req_valid   = 1'b1;
        req_func_id = f6;
        req_op_mnr  = mnr;
        req_sew     = sew;
        req_data0   = d0;
        req_data1   = d1;
        req_mask    = mask;
        if (is_legal(f6, mnr)) begin
            name_q.push_back($sformatf("%s sew%0d", name, sew));
            data_q.push_back(model(f6, mask, sew, d0, d1, req_be));
            side_q.push_back({sew, req_start, req_end, req_be, req_addr});
            due_q.push_back(cyc + 4);  // four register stages
        end
    endtask

    always @(negedge clk) begin
        if (!rst && resp_valid) begin
            if (data_q.size() == 0) begin
                fail_stop("response seen with no request pending");
            end else begin
                check({name_q[0], " data"}, data_q[0], resp_data);
                check({name_q[0], " sideband"}, 64'(side_q[0]),
                      64'({resp_sew, resp_start, resp_end, resp_be, resp_addr}));
                check({name_q[0], " latency"}, 64'(due_q[0]), 64'(cyc));
                void'(name_q.pop_front());
                void'(data_q.pop_front());
                void'(side_q.pop_front());
                void'(due_q.pop_front());
            end
        end
    end

    initial begin
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] r;
        logic [2:0]  mnr;
        logic [5:0]  f6;
        logic [2:0]  sel;
        lfsr        = 32'he5d4_107a;
        rst         = 1'b1;
        req_valid   = 1'b0;
        req_func_id = '0;
        req_op_mnr  = '0;
        req_sew     = '0;
        req_data0   = '0;
        req_data1   = '0;
        req_addr    = '0;
        req_be      = '0;
        req_start   = 1'b0;
        req_end     = 1'b0;
        req_mask    = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int m = 0; m < 3; m++) begin
            mnr = (m == 0) ? valu_pkg::opivv : (m == 1) ? valu_pkg::opivi : valu_pkg::opivx;
            rand_bits(64, a);
            rand_bits(64, b);
            send("and", valu_pkg::f_vand, mnr, 2'd0, a, b, 1'b0);
            send("or", valu_pkg::f_vor, mnr, 2'd1, a, b, 1'b0);
            send("xor", valu_pkg::f_vxor, mnr, 2'd3, a, b, 1'b0);
        end

        for (int s = 0; s < 4; s++) begin
            rand_bits(64, a);
            rand_bits(64, b);
            a = a | 64'h8080_8080_8080_8080;  // every element top bit set
            b = b | 64'h8080_8080_8080_8080;
            send("add", valu_pkg::f_vadd, valu_pkg::opivv, s[1:0], a, b, 1'b0);
            b = b & 64'h7f7f_7f7f_7f7f_7f7f;  // small vs2, so sub borrows
            send("sub", valu_pkg::f_vsub, valu_pkg::opivx, s[1:0], a, b, 1'b0);
            send("rsub", valu_pkg::f_vrsub, valu_pkg::opivi, s[1:0], b, a, 1'b0);
            send("minu", valu_pkg::f_vminu, valu_pkg::opivv, s[1:0], a, b, 1'b0);
            send("min", valu_pkg::f_vmin, valu_pkg::opivx, s[1:0], a, b, 1'b0);
            send("maxu", valu_pkg::f_vmaxu, valu_pkg::opivv, s[1:0], b, a, 1'b0);
            send("max", valu_pkg::f_vmax, valu_pkg::opivi, s[1:0], b, a, 1'b0);
        end

        for (int k = 0; k < 4; k++) begin
            rand_bits(64, a);
            rand_bits(64, b);
            send("merge", valu_pkg::f_vmerge, valu_pkg::opivv, 2'd0, a, b, 1'b0);
            send("move", valu_pkg::f_vmerge, valu_pkg::opivi, 2'd2, a, b, 1'b1);
        end

        // mixed burst, many funct6 and op-minor values are illegal
        for (int k = 0; k < 40; k++) begin
            rand_bits(5, r);
            f6 = {1'b0, r[4:0]};
            rand_bits(3, r);
            mnr = (k % 2 == 0) ? valu_pkg::opivv : r[2:0];
            rand_bits(3, r);
            sel = r[2:0];  // sew and mask
            rand_bits(64, a);
            rand_bits(64, b);
            send("burst", f6, mnr, sel[1:0], a, b, sel[2]);
        end

        @(negedge clk);
        req_valid = 1'b0;
        for (int i = 0; i < 20 && data_q.size() != 0; i++) begin
            @(negedge clk);
        end
        repeat (6) @(negedge clk);  // room for a stray response
        if (data_q.size() != 0) begin
            fail_stop("timeout while waiting for the last responses");
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: valu.f
design/valu_pkg.sv
design/valu_decode.sv
design/valu_logic_unit.sv
design/valu_arith_unit.sv
design/valu_resp_merge.sv
design/valu_top.sv
verif/valu_sva.sv
verif/valu_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= valu_tb
FLIST     ?= valu.f
BUILD     ?= obj_dir
PASS_MSG  := *** PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)
	@out="$$(./$(BUILD)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD)
